// ==== common/cyclic_bram_params.svh ====
// ==============================
// cyclic bram sizing and options
// ==============================
`ifndef CYCLIC_BRAM_PARAMS_SVH
`define CYCLIC_BRAM_PARAMS_SVH

// read side geometry
`define CB_R_DEPTH 16
`define CB_R_WIDTH 8

// write side width, depth follows from total size
`define CB_W_WIDTH 16
`define CB_W_DEPTH ((`CB_R_DEPTH * `CB_R_WIDTH) / `CB_W_WIDTH)

// ram read pipeline depth in enabled cycles
`define CB_LATENCY 3

// absorb fifo, must hold at least CB_LATENCY words
`define CB_FIFO_DEPTH 8

// 1 puts the fifo behind the ram
`define CB_ABSORB 1

`endif

// ==== common/bram_cfg_pkg.sv ====
// ==============================
// cyclic bram address types
// ==============================
`include "cyclic_bram_params.svh"

package bram_cfg_pkg;

  // narrow read side address
  typedef logic [$clog2(`CB_R_DEPTH)-1:0] r_addr_t;

  // wide write side address
  typedef logic [$clog2(`CB_W_DEPTH)-1:0] w_addr_t;

  // window for the cyclic walk
  // read wraps max -> min, write wraps max -> 0
  typedef struct packed {
    r_addr_t r_addr_min;
    r_addr_t r_addr_max;
    w_addr_t w_addr_max;
  } addr_bounds_t;

endpackage

// ==== common/bram_stream_pkg.sv ====
// ==============================
// cyclic bram data beat types
// ==============================
`include "cyclic_bram_params.svh"

package bram_stream_pkg;

  // one wide word on the write side
  typedef struct packed {
    logic [`CB_W_WIDTH-1:0] data;
    logic                   last;
  } w_beat_t;

  // one narrow word on the read side
  typedef logic [`CB_R_WIDTH-1:0] r_word_t;

endpackage

// ==== source/sdp_bram.sv ====
// ==============================
// simple dual port ram, wide write
// narrow read, pipelined output
// ==============================
`timescale 1ns/1ps
`include "cyclic_bram_params.svh"

module sdp_bram (
  input  logic                     clk,
  input  logic                     clken,
  input  logic                     we,
  input  bram_cfg_pkg::w_addr_t    w_addr,
  input  logic [`CB_W_WIDTH-1:0]   w_data,
  input  bram_cfg_pkg::r_addr_t    r_addr,
  output bram_stream_pkg::r_word_t r_data
);

  localparam int RW    = `CB_R_WIDTH;
  localparam int SEL_W = $clog2(`CB_W_WIDTH / `CB_R_WIDTH);
  localparam int R_AW  = $bits(bram_cfg_pkg::r_addr_t);

  logic [`CB_W_WIDTH-1:0] mem [`CB_W_DEPTH];

  logic [`CB_W_WIDTH-1:0]   rd_word;
  logic [SEL_W-1:0]         rd_sel;
  bram_stream_pkg::r_word_t rd_part;

  // read pipeline, stage LATENCY-1 is the port
  bram_stream_pkg::r_word_t [`CB_LATENCY-1:0] pipe;

  always_ff @(posedge clk) begin
    if (clken && we) begin
      mem[w_addr] <= w_data;
    end
  end

  // upper read bits pick the wide word, low bits pick the slice
  // word 2k is the low half of write word k
  assign rd_word = mem[r_addr[R_AW-1:SEL_W]];
  assign rd_sel  = r_addr[SEL_W-1:0];
  assign rd_part = rd_word[rd_sel*RW +: RW];

  always_ff @(posedge clk) begin
    if (clken) begin
      pipe[0] <= rd_part;
      for (int i = 1; i < `CB_LATENCY; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign r_data = pipe[`CB_LATENCY-1];

endmodule

// ==== source/n_delay.sv ====
// ==============================
// n-stage enabled delay line
// ==============================
`timescale 1ns/1ps

module n_delay #(
  parameter int N     = 3,
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             clken,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  logic [N-1:0][WIDTH-1:0] shreg;

  // shifts only on enabled cycles so it tracks the ram pipeline
  always_ff @(posedge clk) begin
    if (reset) begin
      shreg <= '0;
    end else if (clken) begin
      shreg[0] <= data_in;
      for (int i = 1; i < N; i++) begin
        shreg[i] <= shreg[i-1];
      end
    end
  end

  assign data_out = shreg[N-1];

endmodule

// ==== source/absorb_fifo.sv ====
// ==============================
// small fifo that catches ram
// output still in the pipeline
// ==============================
`timescale 1ns/1ps

module absorb_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     clken,
  input  logic                     wr_en,
  input  logic                     rd_en,
  input  bram_stream_pkg::r_word_t din,
  output bram_stream_pkg::r_word_t dout,
  output logic                     valid,
  output logic                     empty,
  output logic                     full
);

  localparam int PTR_W = $clog2(DEPTH);

  bram_stream_pkg::r_word_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign empty = (count == '0);
  assign full  = (count == (PTR_W+1)'(DEPTH));

  // reads on an empty fifo are simply dropped
  assign push = clken && wr_en && !full;
  assign pop  = clken && rd_en && !empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      // one pulse per popped word, not held through a stall
      valid <= pop;
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
    if (pop) begin
      dout <= mem[rd_ptr];
    end
  end

  // the depth must cover every read still in flight in the ram
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    (clken && wr_en) |-> !full)
    else $error("absorb fifo written while full");

  // count never wraps below zero, and empty means the pointers meet
  a_no_phantom_pop: assert property (@(posedge clk) disable iff (reset)
    (count <= (PTR_W+1)'(DEPTH)) && (!empty || (wr_ptr == rd_ptr)))
    else $error("absorb fifo count and pointers out of step");

endmodule

// ==== cyclic_bram/cyclic_addr_gen.sv ====
// ==============================
// wrapping address counter
// ==============================
`timescale 1ns/1ps

module cyclic_addr_gen #(
  parameter int ADDR_WIDTH = 4,
  parameter bit USE_LAST   = 1'b0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  en,
  input  logic                  last_in,
  input  logic [ADDR_WIDTH-1:0] addr_min,
  input  logic [ADDR_WIDTH-1:0] addr_max,
  output logic [ADDR_WIDTH-1:0] addr
);

  logic                  wrap;
  logic [ADDR_WIDTH-1:0] addr_next;

  // external last replaces the compare, for irregular tiles
  assign wrap      = USE_LAST ? last_in : (addr == addr_max);
  assign addr_next = wrap ? addr_min : addr + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      addr <= '0;
    end else if (en) begin
      addr <= addr_next;
    end
  end

  // the walk never leaves the window below the maximum
  a_in_window: assert property (@(posedge clk) disable iff (reset || USE_LAST)
    addr <= addr_max)
    else $error("cyclic address stepped past its maximum");

endmodule

// ==== cyclic_bram/cyclic_bram.sv ====
// ==============================
// cyclic buffer, wide write and
// replayed narrow read window
// ==============================
`timescale 1ns/1ps
`include "cyclic_bram_params.svh"

module cyclic_bram #(
  parameter bit USE_W_LAST = 1'b0,
  parameter bit USE_R_LAST = 1'b0
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         clken,
  input  logic                         w_en,
  input  bram_stream_pkg::w_beat_t     w_beat,
  input  logic                         r_en,
  input  logic                         r_last,
  input  bram_cfg_pkg::addr_bounds_t   bounds,
  output bram_stream_pkg::r_word_t     m_data,
  output logic                         m_valid,
  output logic                         fifo_empty
);

  bram_cfg_pkg::w_addr_t    w_addr;
  bram_cfg_pkg::r_addr_t    r_addr;
  bram_stream_pkg::r_word_t bram_data;
  logic                     w_fire;
  logic                     r_fire;
  logic                     bram_valid;

  assign w_fire = clken && w_en;
  assign r_fire = clken && r_en;

  // write side always restarts at word zero
  cyclic_addr_gen #(
    .ADDR_WIDTH ($bits(bram_cfg_pkg::w_addr_t)),
    .USE_LAST   (USE_W_LAST)
  ) u_w_addr (
    .clk      (clk),
    .reset    (reset),
    .en       (w_fire),
    .last_in  (w_beat.last),
    .addr_min ('0),
    .addr_max (bounds.w_addr_max),
    .addr     (w_addr)
  );

  cyclic_addr_gen #(
    .ADDR_WIDTH ($bits(bram_cfg_pkg::r_addr_t)),
    .USE_LAST   (USE_R_LAST)
  ) u_r_addr (
    .clk      (clk),
    .reset    (reset),
    .en       (r_fire),
    .last_in  (r_last),
    .addr_min (bounds.r_addr_min),
    .addr_max (bounds.r_addr_max),
    .addr     (r_addr)
  );

  sdp_bram u_sdp_bram (
    .clk    (clk),
    .clken  (clken),
    .we     (w_en),
    .w_addr (w_addr),
    .w_data (w_beat.data),
    .r_addr (r_addr),
    .r_data (bram_data)
  );

  // valid strobe walks alongside the ram read pipeline
  n_delay #(
    .N     (`CB_LATENCY),
    .WIDTH (1)
  ) u_valid_delay (
    .clk      (clk),
    .reset    (reset),
    .clken    (clken),
    .data_in  (r_fire),
    .data_out (bram_valid)
  );

  if (`CB_ABSORB) begin : g_absorb
    // consumer pops with r_en, pipeline output lands here
    absorb_fifo #(
      .DEPTH (`CB_FIFO_DEPTH)
    ) u_absorb_fifo (
      .clk   (clk),
      .reset (reset),
      .clken (clken),
      .wr_en (bram_valid),
      .rd_en (r_en),
      .din   (bram_data),
      .dout  (m_data),
      .valid (m_valid),
      .empty (fifo_empty),
      .full  ()
    );
  end else begin : g_direct
    assign m_data     = bram_data;
    assign m_valid    = bram_valid;
    assign fifo_empty = 1'b1;
  end

endmodule

// ==== testbench/cyclic_bram_tb.sv ====
// ==============================
// cyclic bram testbench, directed
// tests against a byte-order model
// ==============================
`timescale 1ns/1ps
`include "cyclic_bram_params.svh"

module cyclic_bram_tb;

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int RATIO          = `CB_W_WIDTH / `CB_R_WIDTH;

  logic                       clk;
  logic                       reset;
  logic                       clken;
  logic                       w_en;
  bram_stream_pkg::w_beat_t   w_beat;
  logic                       r_en;
  logic                       r_last;
  bram_cfg_pkg::addr_bounds_t bounds;
  bram_stream_pkg::r_word_t   m_data;
  logic                       m_valid;
  logic                       fifo_empty;

  // reference copy of the ram and both address walks
  logic [`CB_W_WIDTH-1:0]   model_mem [`CB_W_DEPTH];
  bram_cfg_pkg::r_addr_t    r_addr_m;
  bram_cfg_pkg::w_addr_t    w_addr_m;
  bram_stream_pkg::r_word_t exp_q [$];
  bram_stream_pkg::r_word_t exp_word;
  int                       got_count;
  int                       cycle_count;
  string                    test_name;

  cyclic_bram #(
    .USE_W_LAST (1'b0),
    .USE_R_LAST (1'b0)
  ) u_cyclic_bram (
    .clk        (clk),
    .reset      (reset),
    .clken      (clken),
    .w_en       (w_en),
    .w_beat     (w_beat),
    .r_en       (r_en),
    .r_last     (r_last),
    .bounds     (bounds),
    .m_data     (m_data),
    .m_valid    (m_valid),
    .fifo_empty (fifo_empty)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout in %s: run went past %0d cycles", test_name, TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "run did not finish in time");
    end
  end

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s: expected %0h, actual %0h", test_name, expected, actual);
      $display("Test failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  // word 2k is the low byte of write word k, 2k+1 the high byte
  function automatic bram_stream_pkg::r_word_t expected_byte(input bram_cfg_pkg::r_addr_t a);
    logic [`CB_W_WIDTH-1:0] word;
    word = model_mem[a / RATIO];
    return word[(a % RATIO) * `CB_R_WIDTH +: `CB_R_WIDTH];
  endfunction

  // every enabled read queues the byte it addresses, read before write
  always @(posedge clk) begin
    if (reset) begin
      exp_q.delete();
      r_addr_m = '0;
      w_addr_m = '0;
    end else if (clken) begin
      if (r_en) begin
        exp_q.push_back(expected_byte(r_addr_m));
        r_addr_m = (r_addr_m == bounds.r_addr_max) ? bounds.r_addr_min : r_addr_m + 1'b1;
      end
      if (w_en) begin
        model_mem[w_addr_m] = w_beat.data;
        w_addr_m = (w_addr_m == bounds.w_addr_max) ? '0 : w_addr_m + 1'b1;
      end
    end
  end

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (m_valid) begin
      if (exp_q.size() == 0) begin
        $display("Error in %s: a word came out with no read outstanding", test_name);
        $display("Test failed");
        $fatal(1, "unexpected output word");
      end else begin
        exp_word = exp_q.pop_front();
        check_value(exp_word, m_data);
        got_count++;
      end
    end
  end

  task automatic drive_cycle(input logic we, input logic [`CB_W_WIDTH-1:0] wd,
                             input logic re, input logic ce);
    @(negedge clk);
    w_en        = we;
    w_beat.data = wd;
    w_beat.last = 1'b0;
    r_en        = re;
    clken       = ce;
    @(posedge clk);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    w_en  = 1'b0;
    r_en  = 1'b0;
    clken = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic set_bounds(input int rmin, input int rmax, input int wmax);
    bounds.r_addr_min = bram_cfg_pkg::r_addr_t'(rmin);
    bounds.r_addr_max = bram_cfg_pkg::r_addr_t'(rmax);
    bounds.w_addr_max = bram_cfg_pkg::w_addr_t'(wmax);
  endtask

  task automatic write_random(input int n);
    logic [`CB_W_WIDTH-1:0] data;
    for (int i = 0; i < n; i++) begin
      data = `CB_W_WIDTH'($urandom);
      drive_cycle(1'b1, data, 1'b0, 1'b1);
    end
    drive_cycle(1'b0, '0, 1'b0, 1'b1);
  endtask

  // keeps r_en high until n more words have been delivered
  task automatic read_words(input int n);
    int target;
    target = got_count + n;
    while (got_count < target) begin
      drive_cycle(1'b0, '0, 1'b1, 1'b1);
    end
    drive_cycle(1'b0, '0, 1'b0, 1'b1);
  endtask

  task automatic test_reset_state();
    test_name = "reset_state";
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      check_value(1, fifo_empty);
      check_value(0, m_valid);
    end
  endtask

  task automatic test_fill_replay();
    test_name = "fill_replay";
    apply_reset();
    set_bounds(0, 15, 7);
    write_random(8);
    read_words(40);
  endtask

  task automatic test_partial_window();
    test_name = "partial_window";
    apply_reset();
    set_bounds(4, 9, 7);
    read_words(24);
  endtask

  task automatic test_write_wrap();
    test_name = "write_wrap";
    apply_reset();
    set_bounds(0, 7, 3);
    // words 0 and 1 get written twice
    write_random(6);
    read_words(8);
  endtask

  task automatic test_stall();
    test_name = "stall";
    apply_reset();
    set_bounds(0, 15, 7);
    read_words(5);
    repeat (3) drive_cycle(1'b0, '0, 1'b1, 1'b1);
    // freeze with r_en still asserted
    repeat (4) drive_cycle(1'b0, '0, 1'b1, 1'b0);
    read_words(5);
    for (int i = 0; i < 24; i++) begin
      drive_cycle(1'b0, '0, (i % 3) != 0, 1'b1);
    end
    for (int i = 0; i < 16; i++) begin
      drive_cycle(1'b0, '0, (i % 2) == 0, (i % 4) != 3);
    end
    read_words(6);
  endtask

  initial begin
    void'($urandom(32'h3e1b_6d82));
    reset       = 1'b1;
    clken       = 1'b1;
    w_en        = 1'b0;
    w_beat      = '0;
    r_en        = 1'b0;
    r_last      = 1'b0;
    bounds      = '0;
    got_count   = 0;
    cycle_count = 0;
    test_name   = "startup";
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_fill_replay();
    test_partial_window();
    test_write_wrap();
    test_stall();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== cyclic_bram.f ====
+incdir+common
common/bram_cfg_pkg.sv
common/bram_stream_pkg.sv
source/sdp_bram.sv
source/n_delay.sv
source/absorb_fifo.sv
cyclic_bram/cyclic_addr_gen.sv
cyclic_bram/cyclic_bram.sv
testbench/cyclic_bram_tb.sv

// ==== Bender.yml ====
package:
  name: cyclic_bram

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/bram_cfg_pkg.sv
      - common/bram_stream_pkg.sv
      - source/sdp_bram.sv
      - source/n_delay.sv
      - source/absorb_fifo.sv
      - cyclic_bram/cyclic_addr_gen.sv
      - cyclic_bram/cyclic_bram.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/cyclic_bram_tb.sv
